// File: block_decode.sv
module block_decode (
	input logic clk,
	input logic reset,
	input logic enable,
	input logic tick,
	output logic ready,
	input logic command_reg_write,
	input logic command_instr_write,
	input dsp_core_pkg::block_addr_t command_block_target,
	input logic [dsp_core_pkg::reg_addr_w - 1 : 0] command_reg_target,
	input dsp_core_pkg::instr_t command_instr_write_val,
	input dsp_core_pkg::sample_t command_reg_write_val,
	output dsp_core_pkg::ch_addr_t ch_read_addr_a,
	output dsp_core_pkg::ch_addr_t ch_read_addr_b,
	input dsp_core_pkg::sample_t ch_read_data_a,
	input dsp_core_pkg::sample_t ch_read_data_b,
	output logic frame_start,
	output logic frame_done,
	dsp_issue_if.decode issue,
	dsp_commit_if.monitor commit
);
	import dsp_core_pkg::*;

	typedef enum logic [2 : 0] {
		S_IDLE, S_FETCH, S_LATCH, S_GATHER_A, S_GATHER_B, S_ISSUE, S_WAIT, S_DONE
	} state_t;

	state_t state;
	block_addr_t current_block;
	block_addr_t last_block;
	logic prog_present;
	logic accept;
	instr_t instr_rdata;
	block_fields_t fetched;
	block_fields_t fields;
	logic [block_addr_w + reg_addr_w - 1 : 0] reg_read_addr;
	sample_t reg_rdata;

	assign ready = (state == S_IDLE);
	assign accept = tick & enable & ready;
	assign frame_start = accept;
	assign frame_done = (state == S_DONE);
	assign fetched = block_fields_t'(instr_rdata);

	sync_ram #(.payload_t(instr_t), .depth(n_blocks)) instr_store (
		.clk(clk),
		.write_enable(command_instr_write & ready),
		.write_addr(command_block_target),
		.write_data(command_instr_write_val),
		.read_addr(current_block),
		.read_data(instr_rdata)
	);

	sync_ram #(.payload_t(sample_t), .depth(n_blocks * n_block_regs)) block_regs (
		.clk(clk),
		.write_enable(command_reg_write & ready),
		.write_addr({command_block_target, command_reg_target}),
		.write_data(command_reg_write_val),
		.read_addr(reg_read_addr),
		.read_data(reg_rdata)
	);

	// the a-register read starts straight from the fetched word, so both reads fit in two cycles.
	always_comb begin
		reg_read_addr = {current_block, fields.src_b[reg_addr_w - 1 : 0]};
		if (state == S_LATCH) begin
			reg_read_addr = {current_block, fetched.src_a[reg_addr_w - 1 : 0]};
		end
	end

	assign ch_read_addr_a = fields.src_a;
	assign ch_read_addr_b = fields.src_b;

	assign issue.op = fields.opcode;
	assign issue.shift_amt = fields.src_b;
	assign issue.frac_shift = fields.frac_shift;
	assign issue.saturate = fields.saturate;
	assign issue.dest = fields.dest;

	always_ff @(posedge clk) begin
		if (state == S_LATCH) begin
			fields <= fetched;
		end
		if (state == S_GATHER_A) begin
			issue.operand_a <= fields.src_a_reg ? reg_rdata : ch_read_data_a;
		end
		if (state == S_GATHER_B) begin
			issue.operand_b <= fields.src_b_reg ? reg_rdata : ch_read_data_b;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			current_block <= '0;
			last_block <= '0;
			prog_present <= 1'b0;
			issue.valid <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (command_instr_write) begin
						prog_present <= 1'b1;
						if (!prog_present || command_block_target > last_block) begin
							last_block <= command_block_target;
						end
					end
					if (accept) begin
						current_block <= '0;
						state <= (prog_present | command_instr_write) ? S_FETCH : S_DONE;
					end
				end
				S_FETCH: state <= S_LATCH;
				S_LATCH: state <= S_GATHER_A;
				S_GATHER_A: state <= S_GATHER_B;
				S_GATHER_B: begin
					issue.valid <= 1'b1;
					state <= S_ISSUE;
				end
				S_ISSUE: begin
					if (issue.ready) begin
						issue.valid <= 1'b0;
						state <= S_WAIT;
					end
				end
				S_WAIT: begin
					// the next block may read this result, so nothing moves until it lands.
					if (commit.valid) begin
						if (current_block == last_block) begin
							state <= S_DONE;
						end else begin
							current_block <= current_block + 1'b1;
							state <= S_FETCH;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: block_execute.sv
module block_execute (
	input logic clk,
	input logic reset,
	dsp_issue_if.execute issue,
	dsp_commit_if.driver commit
);
	import dsp_core_pkg::*;

	wide_t a_w;
	wide_t b_w;
	wide_t lim;
	wide_t op_result;
	logic op_writes;
	logic transfer;
	logic mul_pending;
	wide_t product_q;
	logic [3 : 0] frac_q;
	logic sat_q;
	ch_addr_t dest_q;
	sample_t value_q;

	function automatic sample_t clip(wide_t x, logic sat);
		if (sat && x > sat_max) begin
			return sample_t'(sat_max);
		end
		if (sat && x < sat_min) begin
			return sample_t'(sat_min);
		end
		return x[data_width - 1 : 0];
	endfunction

	assign transfer = issue.valid & issue.ready;
	assign issue.ready = ~mul_pending;
	assign commit.dest = dest_q;
	assign commit.value = value_q;

	// results are formed at full width and narrowed afterwards.
	always_comb begin
		a_w = wide_t'(issue.operand_a);
		b_w = wide_t'(issue.operand_b);
		lim = (b_w < 0) ? -b_w : b_w;
		op_result = a_w;
		op_writes = 1'b1;
		case (issue.op)
			OP_ADD: op_result = a_w + b_w;
			OP_SUB: op_result = a_w - b_w;
			OP_ABS: op_result = (a_w < 0) ? -a_w : a_w;
			OP_CLAMP: begin
				if (a_w > lim) begin
					op_result = lim;
				end else if (a_w < -lim) begin
					op_result = -lim;
				end
			end
			OP_LSH: op_result = a_w <<< issue.shift_amt;
			OP_ARSH: op_result = a_w >>> issue.shift_amt;
			OP_MUL: op_result = a_w * b_w;
			OP_MOV: op_result = a_w;
			default: op_writes = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (transfer) begin
			dest_q <= issue.dest;
			sat_q <= issue.saturate;
			frac_q <= issue.frac_shift;
			product_q <= op_result;
			value_q <= clip(op_result, issue.saturate);
		end
		// a Q15 product keeps frac_shift extra integer bits.
		if (mul_pending) begin
			value_q <= clip(product_q >>> (4'd15 - frac_q), sat_q);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mul_pending <= 1'b0;
			commit.valid <= 1'b0;
			commit.write <= 1'b0;
		end else begin
			commit.valid <= 1'b0;
			commit.write <= 1'b0;
			if (mul_pending) begin
				mul_pending <= 1'b0;
				commit.valid <= 1'b1;
				commit.write <= 1'b1;
			end else if (transfer) begin
				if (issue.op == OP_MUL) begin
					mul_pending <= 1'b1;
				end else begin
					commit.valid <= 1'b1;
					commit.write <= op_writes;
				end
			end
		end
	end

endmodule

// File: channel_result.sv
module channel_result (
	input logic clk,
	input logic reset,
	input dsp_core_pkg::sample_t sample_in,
	input logic frame_start,
	input logic frame_done,
	input dsp_core_pkg::ch_addr_t ch_read_addr_a,
	input dsp_core_pkg::ch_addr_t ch_read_addr_b,
	output dsp_core_pkg::sample_t ch_read_data_a,
	output dsp_core_pkg::sample_t ch_read_data_b,
	dsp_commit_if.result commit,
	output dsp_core_pkg::sample_t sample_out
);
	import dsp_core_pkg::*;

	sample_t channels [n_channels];

	assign ch_read_data_a = channels[ch_read_addr_a];
	assign ch_read_data_b = channels[ch_read_addr_b];

	// channels keep their values from one tick to the next.
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < n_channels; i++) begin
				channels[i] <= '0;
			end
		end else begin
			if (frame_start) begin
				channels[0] <= sample_in;
			end
			if (commit.valid && commit.write) begin
				channels[commit.dest] <= commit.value;
			end
		end
	end

	// decode raises frame_done one cycle after the last write.
	always_ff @(posedge clk) begin
		if (reset) begin
			sample_out <= '0;
		end else if (frame_done) begin
			sample_out <= channels[0];
		end
	end

endmodule

// File: dsp_core.sv
module dsp_core (
	input logic clk,
	input logic reset,
	input logic enable,
	input logic tick,
	input dsp_core_pkg::sample_t sample_in,
	output dsp_core_pkg::sample_t sample_out,
	output logic ready,
	input logic command_reg_write,
	input logic command_instr_write,
	input dsp_core_pkg::block_addr_t command_block_target,
	input logic [dsp_core_pkg::reg_addr_w - 1 : 0] command_reg_target,
	input dsp_core_pkg::instr_t command_instr_write_val,
	input dsp_core_pkg::sample_t command_reg_write_val
);
	import dsp_core_pkg::*;

	ch_addr_t ch_read_addr_a;
	ch_addr_t ch_read_addr_b;
	sample_t ch_read_data_a;
	sample_t ch_read_data_b;
	logic frame_start;
	logic frame_done;

	dsp_issue_if issue_bus ();
	dsp_commit_if commit_bus ();

	block_decode u_decode (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.tick(tick),
		.ready(ready),
		.command_reg_write(command_reg_write),
		.command_instr_write(command_instr_write),
		.command_block_target(command_block_target),
		.command_reg_target(command_reg_target),
		.command_instr_write_val(command_instr_write_val),
		.command_reg_write_val(command_reg_write_val),
		.ch_read_addr_a(ch_read_addr_a),
		.ch_read_addr_b(ch_read_addr_b),
		.ch_read_data_a(ch_read_data_a),
		.ch_read_data_b(ch_read_data_b),
		.frame_start(frame_start),
		.frame_done(frame_done),
		.issue(issue_bus),
		.commit(commit_bus)
	);

	block_execute u_execute (
		.clk(clk),
		.reset(reset),
		.issue(issue_bus),
		.commit(commit_bus)
	);

	channel_result u_result (
		.clk(clk),
		.reset(reset),
		.sample_in(sample_in),
		.frame_start(frame_start),
		.frame_done(frame_done),
		.ch_read_addr_a(ch_read_addr_a),
		.ch_read_addr_b(ch_read_addr_b),
		.ch_read_data_a(ch_read_data_a),
		.ch_read_data_b(ch_read_data_b),
		.commit(commit_bus),
		.sample_out(sample_out)
	);

endmodule

// File: dsp_core_if.sv
interface dsp_issue_if;
	import dsp_core_pkg::*;

	logic valid;
	logic ready;
	opcode_t op;
	sample_t operand_a;
	sample_t operand_b;
	logic [3 : 0] shift_amt;
	logic [3 : 0] frac_shift;
	logic saturate;
	ch_addr_t dest;

	modport decode (
		output valid, op, operand_a, operand_b, shift_amt, frac_shift, saturate, dest,
		input ready
	);

	modport execute (
		input valid, op, operand_a, operand_b, shift_amt, frac_shift, saturate, dest,
		output ready
	);
endinterface

interface dsp_commit_if;
	import dsp_core_pkg::*;

	logic valid;
	// cleared when the committed operation leaves the channels untouched.
	logic write;
	ch_addr_t dest;
	sample_t value;

	modport driver (output valid, write, dest, value);

	modport result (input valid, write, dest, value);

	modport monitor (input valid);
endinterface

// File: dsp_core_pkg.sv
package dsp_core_pkg;

	localparam int data_width = 16;
	localparam int n_blocks = 256;
	localparam int n_channels = 16;
	localparam int n_block_regs = 2;

	localparam int block_addr_w = $clog2(n_blocks);
	localparam int ch_addr_w = $clog2(n_channels);
	// selects one register inside a block.
	localparam int reg_addr_w = $clog2(n_block_regs);

	localparam int instr_width = 32;

	localparam int sat_max = 2 ** (data_width - 1) - 1;
	localparam int sat_min = -(2 ** (data_width - 1));

	typedef logic signed [data_width - 1 : 0] sample_t;
	typedef logic signed [2 * data_width - 1 : 0] wide_t;
	typedef logic [block_addr_w - 1 : 0] block_addr_t;
	typedef logic [ch_addr_w - 1 : 0] ch_addr_t;
	typedef logic [instr_width - 1 : 0] instr_t;

	// codes above OP_MOV are treated as no operation by the execute stage.
	typedef enum logic [4 : 0] {
		OP_NOP = 5'd0,
		OP_ADD = 5'd1,
		OP_SUB = 5'd2,
		OP_CLAMP = 5'd3,
		OP_ABS = 5'd4,
		OP_LSH = 5'd5,
		OP_ARSH = 5'd6,
		OP_MUL = 5'd7,
		OP_MOV = 5'd8
	} opcode_t;

	// instruction word, top bit first.
	typedef struct packed {
		opcode_t opcode;
		ch_addr_t src_a;
		// doubles as the shift amount for LSH and ARSH.
		ch_addr_t src_b;
		ch_addr_t dest;
		logic src_a_reg;
		logic src_b_reg;
		logic saturate;
		logic [3 : 0] frac_shift;
		logic [7 : 0] unused;
	} block_fields_t;

endpackage

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_dsp_core \
	-f tb.f -o sim_tb_dsp_core
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/sim_tb_dsp_core 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q "^Test passed$"; then
	exit 0
fi
exit 1

// File: sync_ram.sv
module sync_ram #(
	parameter type payload_t = logic [7 : 0],
	parameter int depth = 256
) (
	input logic clk,
	input logic write_enable,
	input logic [$clog2(depth) - 1 : 0] write_addr,
	input payload_t write_data,
	input logic [$clog2(depth) - 1 : 0] read_addr,
	output payload_t read_data
);

	payload_t mem [depth];

	// read data follows the address by one cycle.
	always_ff @(posedge clk) begin
		if (write_enable) begin
			mem[write_addr] <= write_data;
		end
		read_data <= mem[read_addr];
	end

endmodule

// File: tb.f
dsp_core_pkg.sv
dsp_core_if.sv
sync_ram.sv
block_decode.sv
block_execute.sv
channel_result.sv
dsp_core.sv
tb_dsp_core_properties.sv
tb_dsp_core.sv

// File: tb_dsp_core.sv
module tb_dsp_core;
	timeunit 1ns;
	timeprecision 100ps;
	import dsp_core_pkg::*;

	localparam int prog_len = 8;
	localparam int ticks_per_prog = 4;
	localparam int total_ticks = 2 + (4 + 4 + 3) * ticks_per_prog + 12 + 4;
	localparam int budget_ns = total_ticks * (prog_len + 1) * 12 * 8 + 20000;

	logic clk;
	logic reset;
	logic enable;
	logic tick;
	sample_t sample_in;
	sample_t sample_out;
	logic ready;
	logic command_reg_write;
	logic command_instr_write;
	block_addr_t command_block_target;
	logic [reg_addr_w - 1 : 0] command_reg_target;
	instr_t command_instr_write_val;
	sample_t command_reg_write_val;

	logic [15 : 0] lfsr_state;
	instr_t model_instr [n_blocks];
	sample_t model_regs [n_blocks][2];
	sample_t model_ch [16];
	int model_last;
	bit model_present;
	sample_t expected_q [$];
	int ticks_sent;
	int checks_done;
	logic ready_prev;

	dsp_core DUT (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.tick(tick),
		.sample_in(sample_in),
		.sample_out(sample_out),
		.ready(ready),
		.command_reg_write(command_reg_write),
		.command_instr_write(command_instr_write),
		.command_block_target(command_block_target),
		.command_reg_target(command_reg_target),
		.command_instr_write_val(command_instr_write_val),
		.command_reg_write_val(command_reg_write_val)
	);

	always #4 clk = ~clk;

	function automatic logic [15 : 0] lfsr_next(input logic [15 : 0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hb400;
		end
		return s >> 1;
	endfunction

	function automatic logic [31 : 0] rand_bits(input int n);
		logic [31 : 0] r;
		int i;
		r = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[30 : 0], lfsr_state[0]};
		end
		return r;
	endfunction

	// extreme values come up often enough to reach the saturation limits.
	function automatic sample_t pick_sample();
		if (rand_bits(3) == 0) begin
			return (rand_bits(1) != 0) ? sample_t'(16'h7fff) : sample_t'(16'h8000);
		end
		return sample_t'(rand_bits(16));
	endfunction

	function automatic instr_t encode(input logic [4 : 0] code, input logic [3 : 0] src_a,
		input logic [3 : 0] src_b, input logic [3 : 0] dest, input logic a_reg,
		input logic b_reg, input logic sat, input logic [3 : 0] frac);
		return {code, src_a, src_b, dest, a_reg, b_reg, sat, frac, 8'h00};
	endfunction

	// runs one tick of the program on the model state and returns channel 0.
	function automatic sample_t run_model(input sample_t s);
		instr_t w;
		longint a;
		longint b;
		longint lim;
		longint r;
		bit writes;
		int blk;
		model_ch[0] = s;
		for (blk = 0; model_present && blk <= model_last; blk++) begin
			w = model_instr[blk];
			a = w[14] ? model_regs[blk][w[23]] : model_ch[w[26 : 23]];
			b = w[13] ? model_regs[blk][w[19]] : model_ch[w[22 : 19]];
			r = 0;
			writes = 1'b1;
			case (w[31 : 27])
				5'd1: r = a + b;
				5'd2: r = a - b;
				5'd3: begin
					lim = (b < 0) ? -b : b;
					r = (a > lim) ? lim : ((a < -lim) ? -lim : a);
				end
				5'd4: r = (a < 0) ? -a : a;
				5'd5: r = a <<< w[22 : 19];
				5'd6: r = a >>> w[22 : 19];
				5'd7: r = (a * b) >>> (15 - w[11 : 8]);
				5'd8: r = a;
				default: writes = 1'b0;
			endcase
			if (writes && w[12]) begin
				r = (r > 32767) ? 32767 : ((r < -32768) ? -32768 : r);
			end
			if (writes) begin
				model_ch[w[18 : 15]] = sample_t'(r);
			end
		end
		return model_ch[0];
	endfunction

	task automatic check_value(input sample_t actual, input sample_t expected, input string what);
		if (actual !== expected) begin
			$display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
			$display("Test failed");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	task automatic write_instr(input int blk, input instr_t word);
		@(posedge clk);
		command_instr_write <= 1'b1;
		command_block_target <= block_addr_t'(blk);
		command_instr_write_val <= word;
		@(posedge clk);
		command_instr_write <= 1'b0;
		model_instr[blk] = word;
		if (!model_present || blk > model_last) begin
			model_last = blk;
		end
		model_present = 1'b1;
	endtask

	task automatic write_reg(input int blk, input int sel, input sample_t val);
		@(posedge clk);
		command_reg_write <= 1'b1;
		command_block_target <= block_addr_t'(blk);
		command_reg_target <= sel[0];
		command_reg_write_val <= val;
		@(posedge clk);
		command_reg_write <= 1'b0;
		model_regs[blk][sel] = val;
	endtask

	// kind 0 is add, sub, abs, clamp, mov and an unknown code, kind 1 is mul, kind 2 is shifts.
	task automatic load_program(input int kind);
		logic [4 : 0] code;
		logic [3 : 0] src_a;
		logic [3 : 0] src_b;
		logic [3 : 0] dest;
		logic [3 : 0] frac;
		logic a_reg;
		logic b_reg;
		logic sat;
		int blk;
		for (blk = 0; blk < prog_len; blk++) begin
			if (kind == 0) begin
				case (rand_bits(3))
					0, 5: code = 5'd1;
					1, 6: code = 5'd2;
					2: code = 5'd4;
					3: code = 5'd3;
					4: code = 5'd8;
					default: code = 5'd23;
				endcase
			end else if (kind == 1) begin
				code = 5'd7;
			end else begin
				code = (rand_bits(1) != 0) ? 5'd5 : 5'd6;
			end
			src_a = 4'(rand_bits(4));
			src_b = 4'(rand_bits(4));
			dest = (blk == prog_len - 1) ? 4'd0 : 4'(rand_bits(4));
			frac = 4'(rand_bits(4));
			a_reg = (rand_bits(2) == 0);
			b_reg = (kind == 1) || (rand_bits(2) == 0);
			sat = (rand_bits(1) != 0);
			write_instr(blk, encode(code, src_a, src_b, dest, a_reg, b_reg, sat, frac));
			write_reg(blk, 0, pick_sample());
			write_reg(blk, 1, pick_sample());
		end
	endtask

	// channel 1 sums every input sample and is copied back to channel 0.
	task automatic load_feedback();
		int blk;
		write_instr(0, encode(5'd1, 4'd1, 4'd0, 4'd1, 1'b0, 1'b0, 1'b0, 4'd0));
		write_instr(1, encode(5'd8, 4'd1, 4'd0, 4'd0, 1'b0, 1'b0, 1'b0, 4'd0));
		// a zero coefficient in block 2 makes any stray register write visible at the output.
		write_instr(2, encode(5'd1, 4'd0, 4'd0, 4'd0, 1'b0, 1'b1, 1'b0, 4'd0));
		write_reg(2, 0, '0);
		for (blk = 3; blk < prog_len; blk++) begin
			write_instr(blk, '0);
		end
	endtask

	task automatic run_tick(input sample_t s, input bit disturb);
		expected_q.push_back(run_model(s));
		ticks_sent++;
		@(posedge clk);
		tick <= 1'b1;
		sample_in <= s;
		@(posedge clk);
		tick <= 1'b0;
		// the core is busy here, so this tick and both writes have to be dropped.
		if (disturb) begin
			repeat (2) @(posedge clk);
			tick <= 1'b1;
			sample_in <= pick_sample();
			command_instr_write <= 1'b1;
			command_reg_write <= 1'b1;
			command_block_target <= block_addr_t'(2);
			command_reg_target <= '0;
			command_instr_write_val <= rand_bits(32);
			command_reg_write_val <= pick_sample();
			@(posedge clk);
			tick <= 1'b0;
			command_instr_write <= 1'b0;
			command_reg_write <= 1'b0;
		end
		while (checks_done < ticks_sent) begin
			@(posedge clk);
		end
	endtask

	// a rising ready ends the run that the oldest pending tick started.
	initial begin
		ready_prev = 1'b1;
		forever begin
			@(negedge clk);
			if (!reset && ready === 1'b1 && !ready_prev) begin
				if (expected_q.size() == 0) begin
					$display("ready rose at %0t ns with no tick pending", $time);
					$display("Test failed");
					$fatal(1, "unexpected end of run");
				end else begin
					check_value(sample_out, expected_q.pop_front(), "sample_out");
					checks_done++;
				end
			end
			if (!reset) begin
				ready_prev = ready;
			end
		end
	end

	initial begin
		#(budget_ns);
		$display("watchdog stopped the run after %0d ns without finishing", budget_ns);
		$display("Test failed");
		$fatal(1, "timeout");
	end

	initial begin
		int p;
		int k;
		clk = 1'b0;
		reset = 1'b1;
		enable = 1'b1;
		tick = 1'b0;
		sample_in = '0;
		command_reg_write = 1'b0;
		command_instr_write = 1'b0;
		command_block_target = '0;
		command_reg_target = '0;
		command_instr_write_val = '0;
		command_reg_write_val = '0;
		lfsr_state = 16'd94;
		model_present = 1'b0;
		model_last = 0;
		ticks_sent = 0;
		checks_done = 0;
		for (k = 0; k < 16; k++) begin
			model_ch[k] = '0;
		end
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		repeat (2) run_tick(pick_sample(), 1'b0);
		for (p = 0; p < 4; p++) begin
			load_program(0);
			repeat (ticks_per_prog) run_tick(pick_sample(), 1'b0);
		end
		for (p = 0; p < 4; p++) begin
			load_program(1);
			repeat (ticks_per_prog) run_tick(pick_sample(), 1'b0);
		end
		for (p = 0; p < 3; p++) begin
			load_program(2);
			repeat (ticks_per_prog) run_tick(pick_sample(), 1'b0);
		end
		load_feedback();
		repeat (12) run_tick(pick_sample(), 1'b0);
		repeat (4) run_tick(pick_sample(), 1'b1);

		repeat (4) @(posedge clk);
		if (checks_done == total_ticks && expected_q.size() == 0) begin
			$display("Test passed");
			$finish;
		end else begin
			$display("only %0d of %0d ticks were checked", checks_done, total_ticks);
			$display("Test failed");
			$fatal(1, "missing results");
		end
	end

endmodule

// File: tb_dsp_core_properties.sv
module tb_dsp_core_properties (
	input logic clk,
	input logic reset,
	input logic enable,
	input logic tick,
	input logic ready,
	input dsp_core_pkg::sample_t sample_out
);
	timeunit 1ns;
	timeprecision 100ps;

	// every run lasts at least one cycle, even with no program.
	tick_lowers_ready: assert property (
		@(posedge clk) disable iff (reset)
		(tick && enable && ready) |=> !ready
	) else $error("ready stayed high after an accepted tick");

	// the output register only loads on the edge that ends a run.
	output_moves_with_ready: assert property (
		@(posedge clk) disable iff (reset)
		!$stable(sample_out) |-> $rose(ready)
	) else $error("sample_out changed without ready rising");

	idle_holds_ready: assert property (
		@(posedge clk) disable iff (reset)
		(ready && !(tick && enable)) |=> ready
	) else $error("ready dropped with no accepted tick");

endmodule

bind dsp_core tb_dsp_core_properties handshake_checks (
	.clk(clk),
	.reset(reset),
	.enable(enable),
	.tick(tick),
	.ready(ready),
	.sample_out(sample_out)
);
